// File: coreDefs.sv
/* Encodings and widths for the 16-bit single-cycle core.
   Field positions follow the fixed 4/3/3/3 instruction format; codes 11 to 15 decode as NOP. */
package coreDefs;

	// Basic widths.
	localparam int DATA_W    = 16;
	localparam int INSTR_W   = 16;
	localparam int ADDR_W    = 3;
	localparam int SHAMT_W   = 4;
	localparam int REG_COUNT = 8;

	// Instruction field positions.
	localparam int OPC_MSB  = 15;
	localparam int OPC_LSB  = 12;
	localparam int RD_MSB   = 11;
	localparam int RD_LSB   = 9;
	localparam int RS1_MSB  = 8;
	localparam int RS1_LSB  = 6;
	localparam int RS2_MSB  = 5;
	localparam int RS2_LSB  = 3;
	localparam int IMM8_MSB = 7;
	localparam int IMM8_LSB = 0;
	localparam int IMM6_MSB = 5;
	localparam int IMM6_LSB = 0;

	// Immediate widths, derived from the field positions.
	localparam int IMM8_W = IMM8_MSB - IMM8_LSB + 1;
	localparam int IMM6_W = IMM6_MSB - IMM6_LSB + 1;

	// Vectors with a meaning of their own.
	typedef logic [DATA_W-1:0]  dataWord_t;
	typedef logic [ADDR_W-1:0]  regAddr_t;
	typedef logic [INSTR_W-1:0] instr_t;
	typedef logic [SHAMT_W-1:0] shamt_t;

	// Opcodes, as found in bits 15 to 12.
	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_XOR  = 4'd5,
		OP_SHL  = 4'd6,
		OP_SHR  = 4'd7,
		OP_LDI  = 4'd8,
		OP_ADDI = 4'd9,
		OP_OUT  = 4'd10
	} opcode_t;

	// ALU function select.
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHL,
		ALU_SHR,
		ALU_PASSB
	} aluOp_t;

endpackage

// File: RegFile.sv
/* Eight 16-bit registers, two combinational reads, one write per edge.
   There is no bypass; a read in the write cycle still returns the old value. */
`timescale 1ns/1ps

module RegFile
	import coreDefs::*;
(
	// Common signals.
	input  logic      i_clk,
	input  logic      i_rstN,

	// Read addresses.
	input  regAddr_t  i_rAddr1,
	input  regAddr_t  i_rAddr2,

	// Write port, taken at the rising edge.
	input  dataWord_t i_wData,
	input  regAddr_t  i_wAddr,
	input  logic      i_wEn,

	// Read data, straight from the storage.
	output dataWord_t o_rData1,
	output dataWord_t o_rData2
);

	// Storage for the eight words.
	dataWord_t regs [REG_COUNT];

	// One enable per word, decoded from the write address.
	logic [REG_COUNT-1:0] wordEn;

	// Write address decode.
	// At most one bit is set, and none when i_wEn is low.
	always_comb begin
		wordEn = '0;
		if (i_wEn) begin
			wordEn[i_wAddr] = 1'b1;
		end
	end

	// Register update.
	// Reset clears every word, so reads after reset return zero.
	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < REG_COUNT; i++) begin
				// Only the addressed word takes the new data.
				if (wordEn[i]) begin
					regs[i] <= i_wData;
				end
			end
		end
	end

	// First read port.
	// Pure select, no path from the write data.
	assign o_rData1 = regs[i_rAddr1];

	// Second read port.
	assign o_rData2 = regs[i_rAddr2];

	// An unknown write address would corrupt an unknown word.
	// Checked only outside reset, when the decoder drives valid fields.
	wAddrKnown: assert property (
		@(posedge i_clk) disable iff (!i_rstN)
		i_wEn |-> !$isunknown(i_wAddr)
	) else $error("RegFile: write enabled with unknown address %b", i_wAddr);

endmodule

// File: Alu.sv
/* Combinational ALU with 16-bit wraparound and no carry or overflow out.
   Shifts take the low four bits of the B operand; SHR is logical. */
`timescale 1ns/1ps

module Alu
	import coreDefs::*;
(
	// Function select from the decoder.
	input  aluOp_t    i_op,

	// Operands.
	// A is always rs1, B is rs2 or the immediate.
	input  dataWord_t i_a,
	input  dataWord_t i_b,

	// Result and its zero test.
	output dataWord_t o_result,
	output logic      o_isZero
);

	// Shift amount, low bits of B.
	shamt_t    shamt;

	// Selected result before it leaves the block.
	dataWord_t result;

	assign shamt = i_b[SHAMT_W-1:0];

	// Function select.
	// Sums and differences drop the carry out of bit 15.
	always_comb begin
		case (i_op)
			ALU_ADD: begin
				result = i_a + i_b;
			end
			ALU_SUB: begin
				result = i_a - i_b;
			end
			ALU_AND: begin
				result = i_a & i_b;
			end
			ALU_OR: begin
				result = i_a | i_b;
			end
			ALU_XOR: begin
				result = i_a ^ i_b;
			end
			ALU_SHL: begin
				// Zeros shift in from the right.
				result = i_a << shamt;
			end
			ALU_SHR: begin
				// Zeros shift in from the left, no sign fill.
				result = i_a >> shamt;
			end
			ALU_PASSB: begin
				// Used by LDI to load the immediate.
				result = i_b;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign o_result = result;

	// Zero test on the full word.
	// The top level samples it only on register writes.
	assign o_isZero = (result == '0);

endmodule

// File: InstrDecode.sv
/* Purely combinational decode; every enable is forced low while i_instrValid is low.
   Undefined opcodes 11 to 15 produce no write and no output strobe. */
`timescale 1ns/1ps

module InstrDecode
	import coreDefs::*;
(
	// Instruction and its strobe.
	input  instr_t    i_instr,
	input  logic      i_instrValid,

	// Register file addresses.
	output regAddr_t  o_rAddr1,
	output regAddr_t  o_rAddr2,
	output regAddr_t  o_wAddr,
	output logic      o_wEn,

	// ALU controls.
	output aluOp_t    o_aluOp,
	output logic      o_useImm,
	output dataWord_t o_imm,

	// OUT request.
	output logic      o_outStrobe
);

	// Instruction fields.
	opcode_t            opcode;
	logic [IMM8_W-1:0]  imm8;
	logic [IMM6_W-1:0]  imm6;

	assign opcode = opcode_t'(i_instr[OPC_MSB:OPC_LSB]);
	assign imm8   = i_instr[IMM8_MSB:IMM8_LSB];
	assign imm6   = i_instr[IMM6_MSB:IMM6_LSB];

	// Register fields go out as they are.
	// Immediate forms overlap rs1 and rs2, which is harmless.
	assign o_wAddr  = i_instr[RD_MSB:RD_LSB];
	assign o_rAddr1 = i_instr[RS1_MSB:RS1_LSB];
	assign o_rAddr2 = i_instr[RS2_MSB:RS2_LSB];

	// Opcode decode.
	always_comb begin
		o_wEn       = 1'b0;
		o_outStrobe = 1'b0;
		o_useImm    = 1'b0;
		o_aluOp     = ALU_PASSB;
		// LDI form by default, zero-extended.
		o_imm       = {{(DATA_W-IMM8_W){1'b0}}, imm8};
		case (opcode)
			OP_ADD: begin
				o_aluOp = ALU_ADD;
				o_wEn   = i_instrValid;
			end
			OP_SUB: begin
				o_aluOp = ALU_SUB;
				o_wEn   = i_instrValid;
			end
			OP_AND: begin
				o_aluOp = ALU_AND;
				o_wEn   = i_instrValid;
			end
			OP_OR: begin
				o_aluOp = ALU_OR;
				o_wEn   = i_instrValid;
			end
			OP_XOR: begin
				o_aluOp = ALU_XOR;
				o_wEn   = i_instrValid;
			end
			OP_SHL: begin
				o_aluOp = ALU_SHL;
				o_wEn   = i_instrValid;
			end
			OP_SHR: begin
				o_aluOp = ALU_SHR;
				o_wEn   = i_instrValid;
			end
			OP_LDI: begin
				// Immediate passes straight through the ALU.
				o_aluOp  = ALU_PASSB;
				o_useImm = 1'b1;
				o_wEn    = i_instrValid;
			end
			OP_ADDI: begin
				// Signed six-bit offset, range -32 to 31.
				o_aluOp  = ALU_ADD;
				o_useImm = 1'b1;
				o_imm    = {{(DATA_W-IMM6_W){imm6[IMM6_W-1]}}, imm6};
				o_wEn    = i_instrValid;
			end
			OP_OUT: begin
				o_outStrobe = i_instrValid;
			end
			default: begin
				// NOP and undefined codes, nothing to do.
			end
		endcase
	end

	// No opcode both writes a register and drives the port.
	always_comb begin
		assert (!(o_wEn && o_outStrobe))
			else $error("InstrDecode: write and OUT strobe together, opcode %0d", opcode);
	end

endmodule

// File: CoreDatapath.sv
/* Single-cycle core; one instruction per cycle with no back-pressure.
   o_outData holds the last OUT value; o_outValid pulses for one cycle. */
`timescale 1ns/1ps

module CoreDatapath
	import coreDefs::*;
(
	// Common signals.
	input  logic      i_clk,
	input  logic      i_rstN,

	// Instruction stream.
	input  instr_t    i_instr,
	input  logic      i_instrValid,

	// Output port and status.
	output dataWord_t o_outData,
	output logic      o_outValid,
	output logic      o_zero
);

	// Decode outputs.
	regAddr_t  rAddr1;
	regAddr_t  rAddr2;
	regAddr_t  wAddr;
	logic      wEn;
	aluOp_t    aluOp;
	logic      useImm;
	dataWord_t imm;
	logic      outStrobe;

	// Register file and ALU nets.
	dataWord_t rData1;
	dataWord_t rData2;
	dataWord_t aluB;
	dataWord_t aluResult;
	logic      aluZero;

	InstrDecode u_decode (
		.i_instr      (i_instr),
		.i_instrValid (i_instrValid),
		.o_rAddr1     (rAddr1),
		.o_rAddr2     (rAddr2),
		.o_wAddr      (wAddr),
		.o_wEn        (wEn),
		.o_aluOp      (aluOp),
		.o_useImm     (useImm),
		.o_imm        (imm),
		.o_outStrobe  (outStrobe)
	);

	// ALU result goes straight back as write data.
	RegFile u_regFile (
		.i_clk    (i_clk),
		.i_rstN   (i_rstN),
		.i_rAddr1 (rAddr1),
		.i_rAddr2 (rAddr2),
		.i_wData  (aluResult),
		.i_wAddr  (wAddr),
		.i_wEn    (wEn),
		.o_rData1 (rData1),
		.o_rData2 (rData2)
	);

	// Immediate replaces rs2 for LDI and ADDI.
	assign aluB = useImm ? imm : rData2;

	Alu u_alu (
		.i_op     (aluOp),
		.i_a      (rData1),
		.i_b      (aluB),
		.o_result (aluResult),
		.o_isZero (aluZero)
	);

	// Zero flag.
	// Follows the written result, holds on every other cycle.
	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			o_zero <= 1'b0;
		end else if (wEn) begin
			o_zero <= aluZero;
		end
	end

	// Output port.
	// Data is captured from rs1 and held until the next OUT.
	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			o_outData  <= '0;
			o_outValid <= 1'b0;
		end else begin
			o_outValid <= outStrobe;
			if (outStrobe) begin
				o_outData <= rData1;
			end
		end
	end

endmodule

// File: tbCoreDatapath.sv
/* Directed testbench for the single-cycle core; all stimulus changes on the falling edge.
   Register contents are observed only through OUT, and a reference model tracks every write. */
`timescale 1ns/1ps

module tbCoreDatapath
	import coreDefs::*;
;

	// Run limit, well above the length of all tests together.
	localparam int TIMEOUT_CYCLES = 2000;

	// DUT signals.
	logic      i_clk;
	logic      i_rstN;
	instr_t    i_instr;
	logic      i_instrValid;
	dataWord_t o_outData;
	logic      o_outValid;
	logic      o_zero;

	// Reference model state.
	dataWord_t modelRegs [REG_COUNT];
	logic      modelZero;

	// Bookkeeping.
	int          errorCount;
	int          checkCount;
	int          cycleCount;
	logic [31:0] lfsrState;

	CoreDatapath i_dut (
		.i_clk        (i_clk),
		.i_rstN       (i_rstN),
		.i_instr      (i_instr),
		.i_instrValid (i_instrValid),
		.o_outData    (o_outData),
		.o_outValid   (o_outValid),
		.o_zero       (o_zero)
	);

	// Free-running 10 ns clock.
	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// Timeout guard.
	always @(posedge i_clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Random source and instruction encoders
	//////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR, taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken.
	function automatic dataWord_t randBits(input int nBits);
		dataWord_t v;
		v = '0;
		for (int i = 0; i < nBits; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[14:0], lfsrState[0]};
		end
		return v;
	endfunction

	// Register form, low three bits unused.
	function automatic instr_t encReg(input opcode_t op, input regAddr_t rd,
			input regAddr_t rs1, input regAddr_t rs2);
		return {op, rd, rs1, rs2, 3'b000};
	endfunction

	function automatic instr_t encLdi(input regAddr_t rd, input logic [7:0] imm8);
		return {OP_LDI, rd, 1'b0, imm8};
	endfunction

	function automatic instr_t encAddi(input regAddr_t rd, input regAddr_t rs1,
			input logic [5:0] imm6);
		return {OP_ADDI, rd, rs1, imm6};
	endfunction

	// Source register sits in the rs1 field.
	function automatic instr_t encOut(input regAddr_t rs);
		return {OP_OUT, 3'b000, rs, 6'b000000};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model, drive and check helpers
	//////////////////////////////////////////////////////////////////////

	// Both operands come from the state before the write.
	task automatic applyModel(input instr_t ins, input logic valid);
		dataWord_t a;
		dataWord_t b;
		dataWord_t res;
		logic      doWrite;
		a       = modelRegs[ins[8:6]];
		b       = modelRegs[ins[5:3]];
		res     = '0;
		doWrite = 1'b1;
		case (ins[15:12])
			OP_ADD:  res = a + b;
			OP_SUB:  res = a - b;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_SHL:  res = a << b[3:0];
			OP_SHR:  res = a >> b[3:0];
			OP_LDI:  res = {8'h00, ins[7:0]};
			OP_ADDI: res = a + {{10{ins[5]}}, ins[5:0]};
			default: doWrite = 1'b0;
		endcase
		if (valid && doWrite) begin
			modelRegs[ins[11:9]] = res;
			modelZero = (res == 16'h0000);
		end
	endtask

	task automatic checkValue(input string testName, input dataWord_t expected,
			input dataWord_t actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("[FAIL] %s: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	// Called on a falling edge, returns on the next one.
	task automatic issueInstr(input instr_t ins, input logic valid);
		i_instr      = ins;
		i_instrValid = valid;
		@(negedge i_clk);
		applyModel(ins, valid);
	endtask

	task automatic idleCycle();
		i_instr      = '0;
		i_instrValid = 1'b0;
		@(negedge i_clk);
	endtask

	// OUT, then pulse, data and flag checks.
	task automatic readOut(input regAddr_t r, input string testName);
		issueInstr(encOut(r), 1'b1);
		if (!o_outValid) begin
			errorCount++;
			$display("%s: o_outValid did not pulse in the cycle after OUT of r%0d", testName, r);
		end else begin
			checkValue(testName, modelRegs[r], o_outData);
		end
		checkValue({testName, " zero flag"}, 16'(modelZero), 16'(o_zero));
		idleCycle();
		if (o_outValid) begin
			errorCount++;
			$display("%s: o_outValid stayed high for more than one cycle", testName);
		end
	endtask

	task automatic readAll(input string testName);
		for (int r = 0; r < REG_COUNT; r++) begin
			readOut(3'(r), testName);
		end
	endtask

	// Builds a 16-bit value from two bytes, r7 is scratch.
	task automatic loadWord(input regAddr_t r, input dataWord_t value);
		issueInstr(encLdi(r, value[15:8]), 1'b1);
		issueInstr(encLdi(3'd7, 8'd8), 1'b1);
		issueInstr(encReg(OP_SHL, r, r, 3'd7), 1'b1);
		issueInstr(encLdi(3'd7, value[7:0]), 1'b1);
		issueInstr(encReg(OP_OR, r, r, 3'd7), 1'b1);
	endtask

	task automatic runAndRead(input instr_t ins, input regAddr_t rd, input string testName);
		issueInstr(ins, 1'b1);
		readOut(rd, testName);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic testResetState();
		checkValue("reset outValid", 16'h0000, 16'(o_outValid));
		checkValue("reset zero", 16'h0000, 16'(o_zero));
		checkValue("reset outData", 16'h0000, o_outData);
		readAll("reset regs");
	endtask

	// Register 0 is an ordinary register.
	task automatic testLoadReadOut();
		for (int r = 0; r < REG_COUNT; r++) begin
			issueInstr(encLdi(3'(r), 8'(r * 37 + 5)), 1'b1);
		end
		readAll("load readout");
	endtask

	task automatic testAluOps();
		dataWord_t a;
		dataWord_t b;
		dataWord_t imm;
		for (int iter = 0; iter < 4; iter++) begin
			a = randBits(16);
			b = randBits(16);
			loadWord(3'd1, a);
			loadWord(3'd2, b);
			readOut(3'd1, "alu operand a");
			readOut(3'd2, "alu operand b");
			runAndRead(encReg(OP_ADD, 3'd3, 3'd1, 3'd2), 3'd3, "alu ADD");
			runAndRead(encReg(OP_SUB, 3'd3, 3'd1, 3'd2), 3'd3, "alu SUB");
			runAndRead(encReg(OP_AND, 3'd3, 3'd1, 3'd2), 3'd3, "alu AND");
			runAndRead(encReg(OP_OR, 3'd3, 3'd1, 3'd2), 3'd3, "alu OR");
			runAndRead(encReg(OP_XOR, 3'd3, 3'd1, 3'd2), 3'd3, "alu XOR");
			runAndRead(encReg(OP_SHL, 3'd4, 3'd1, 3'd2), 3'd4, "alu SHL");
			runAndRead(encReg(OP_SHR, 3'd4, 3'd1, 3'd2), 3'd4, "alu SHR");
			// Negative offset, then positive.
			imm = randBits(5);
			runAndRead(encAddi(3'd5, 3'd1, {1'b1, imm[4:0]}), 3'd5, "alu ADDI neg");
			imm = randBits(5);
			runAndRead(encAddi(3'd5, 3'd1, {1'b0, imm[4:0]}), 3'd5, "alu ADDI pos");
		end
	endtask

	// Each instruction reads the previous result one cycle later.
	task automatic testBackToBack();
		dataWord_t seed;
		seed = randBits(8);
		issueInstr(encLdi(3'd1, seed[7:0]), 1'b1);
		issueInstr(encAddi(3'd2, 3'd1, 6'h05), 1'b1);
		issueInstr(encReg(OP_ADD, 3'd3, 3'd2, 3'd1), 1'b1);
		issueInstr(encReg(OP_SUB, 3'd4, 3'd3, 3'd2), 1'b1);
		issueInstr(encReg(OP_XOR, 3'd5, 3'd4, 3'd3), 1'b1);
		issueInstr(encReg(OP_SHL, 3'd6, 3'd5, 3'd2), 1'b1);
		issueInstr(encReg(OP_SHR, 3'd0, 3'd6, 3'd1), 1'b1);
		issueInstr(encAddi(3'd0, 3'd0, 6'h3f), 1'b1);
		issueInstr(encReg(OP_AND, 3'd1, 3'd0, 3'd5), 1'b1);
		issueInstr(encAddi(3'd7, 3'd1, 6'h01), 1'b1);
		issueInstr(encAddi(3'd7, 3'd7, 6'h01), 1'b1);
		readAll("back to back");
	endtask

	task automatic testNoChange();
		dataWord_t fieldBits;
		// Flag set first, so a stray write would show.
		issueInstr(encReg(OP_SUB, 3'd7, 3'd7, 3'd7), 1'b1);
		checkValue("nochange zero set", 16'h0001, 16'(o_zero));
		issueInstr(encLdi(3'd1, 8'hff), 1'b0);
		issueInstr(encReg(OP_ADD, 3'd2, 3'd1, 3'd1), 1'b0);
		issueInstr(encOut(3'd3), 1'b0);
		if (o_outValid) begin
			errorCount++;
			$display("nochange: o_outValid pulsed for an OUT with i_instrValid low");
		end
		fieldBits = randBits(12);
		issueInstr({OP_NOP, fieldBits[11:0]}, 1'b1);
		for (int code = 11; code <= 15; code++) begin
			fieldBits = randBits(12);
			issueInstr({4'(code), fieldBits[11:0]}, 1'b1);
		end
		checkValue("nochange zero held", 16'h0001, 16'(o_zero));
		readAll("nochange regs");
	endtask

	task automatic testZeroFlag();
		issueInstr(encLdi(3'd5, 8'h5a), 1'b1);
		checkValue("zero after nonzero LDI", 16'h0000, 16'(o_zero));
		issueInstr(encReg(OP_SUB, 3'd5, 3'd5, 3'd5), 1'b1);
		checkValue("zero after SUB self", 16'h0001, 16'(o_zero));
		readOut(3'd2, "zero across OUT set");
		issueInstr(encReg(OP_NOP, 3'd1, 3'd2, 3'd3), 1'b1);
		checkValue("zero after NOP set", 16'h0001, 16'(o_zero));
		issueInstr(encLdi(3'd5, 8'h01), 1'b0);
		checkValue("zero after invalid LDI", 16'h0001, 16'(o_zero));
		issueInstr(encLdi(3'd6, 8'h01), 1'b1);
		checkValue("zero after LDI one", 16'h0000, 16'(o_zero));
		issueInstr(encReg(OP_SUB, 3'd6, 3'd6, 3'd6), 1'b0);
		checkValue("zero after invalid SUB", 16'h0000, 16'(o_zero));
		readOut(3'd6, "zero across OUT clear");
		issueInstr(encAddi(3'd6, 3'd6, 6'h3f), 1'b1);
		checkValue("zero after ADDI to zero", 16'h0001, 16'(o_zero));
		readAll("zero regs");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		i_rstN       = 1'b0;
		i_instr      = '0;
		i_instrValid = 1'b0;
		errorCount   = 0;
		checkCount   = 0;
		cycleCount   = 0;
		lfsrState    = 32'hca024a5d;
		modelZero    = 1'b0;
		for (int r = 0; r < REG_COUNT; r++) begin
			modelRegs[r] = '0;
		end

		// Ten cycles of reset, released on a falling edge.
		repeat (10) @(posedge i_clk);
		@(negedge i_clk);
		i_rstN = 1'b1;

		testResetState();
		testLoadReadOut();
		testAluOps();
		testBackToBack();
		testNoChange();
		testZeroFlag();

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: verilog.f
coreDefs.sv
RegFile.sv
Alu.sv
InstrDecode.sv
CoreDatapath.sv
tbCoreDatapath.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tbCoreDatapath
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = *** TEST FAILED ***
PASS_MSG  = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
